// File: project.f
rtl/core_isa_pkg.sv
rtl/core_link_pkg.sv
rtl/core_alu_shifter.sv
rtl/core_alu.sv
rtl/core_alu_issue.sv
rtl/core_alu_fifo.sv
rtl/core_alu_exec.sv
rtl/core_alu_top.sv
sim/tb_clock.sv
sim/tb_core_alu.sv

// File: sim/tb_core_alu.sv
`timescale 1ns/1ps

module tb_core_alu;

	import core_isa_pkg::*;
	import core_link_pkg::*;

	localparam int W           = 16;
	localparam int DEPTH       = 4;
	localparam int N_RANDOM    = 400;
	localparam int ACK_LIMIT   = 200;
	localparam int DRAIN_LIMIT = 1000;

	logic      clk;
	logic      arst_n;
	alu_cmd    cmd;
	logic      cmd_req;
	logic      cmd_ack;
	alu_result res;
	logic      res_req;
	logic      res_ack;

	alu_result exp_q[$];
	alu_cmd    first_cmd;
	psr_flags  model_flags;
	logic      hold_ack;
	logic      ack_seen;
	bit        timed_out;
	int        ack_delay;
	int        err_value;
	int        err_other;
	int        n_checked;
	int        seed;
	int        i;

	tb_clock #(.PERIOD(8.0)) clock (.clk(clk));

	core_alu_top #(.W(W), .DEPTH(DEPTH)) dut (
		.clk     (clk),
		.arst_n  (arst_n),
		.cmd     (cmd),
		.cmd_req (cmd_req),
		.cmd_ack (cmd_ack),
		.res     (res),
		.res_req (res_req),
		.res_ack (res_ack)
	);

	// returns {carry, value} for a register-specified shift.
	function automatic logic [W:0] shift_model(shift_op shop, logic [W-1:0] base,
	                                           logic [7:0] amt, logic c_in);
		int n;
		n = amt;
		if (n == 0)
			return {c_in, base};
		case (shop)
			SHIFT_LSL: begin
				if (n < W)
					return {base[W-n], base << n};
				else if (n == W)
					return {base[0], {W{1'b0}}};
				return '0;
			end
			SHIFT_LSR: begin
				if (n < W)
					return {base[n-1], base >> n};
				else if (n == W)
					return {base[W-1], {W{1'b0}}};
				return '0;
			end
			SHIFT_ASR: begin
				if (n < W)
					return {base[n-1], W'($signed(base) >>> n)};
				return {(W + 1){base[W-1]}};
			end
			default: begin
				n = n % W;
				if (n == 0)
					return {base[W-1], base};
				return {base[n-1], W'((base >> n) | (base << (W - n)))};
			end
		endcase
	endfunction

	function automatic alu_result predict(alu_cmd cin, psr_flags f);
		alu_result    r;
		logic [W:0]   sh;
		logic [W-1:0] a;
		logic [W-1:0] b;
		logic [W-1:0] q;
		logic         arith;
		logic         sub;
		logic         swap;
		logic         cmp_op;
		logic         nc;
		logic         nv;
		int           x;
		int           y;
		int           sx;
		int           sy;
		int           extra;
		int           u;
		int           s;
		sh = shift_model(cin.ctrl.shop, cin.base, cin.shift, f.c);
		a = cin.a;
		b = sh[W-1:0];
		arith = 1'b1;
		sub = 1'b0;
		swap = 1'b0;
		extra = 0;
		case (cin.ctrl.op)
			ALU_ADD, ALU_CMN: extra = 0;
			ALU_ADC: extra = f.c;
			ALU_SUB, ALU_CMP: sub = 1'b1;
			ALU_SBC: begin
				sub = 1'b1;
				extra = !f.c;
			end
			ALU_RSB: begin
				sub = 1'b1;
				swap = 1'b1;
			end
			ALU_RSC: begin
				sub = 1'b1;
				swap = 1'b1;
				extra = !f.c;
			end
			default: arith = 1'b0;
		endcase
		x = swap ? b : a;
		y = swap ? a : b;
		sx = swap ? $signed(b) : $signed(a);
		sy = swap ? $signed(a) : $signed(b);
		// C is the unsigned carry out, or no borrow for a subtraction.
		if (sub) begin
			u = x - y - extra;
			s = sx - sy - extra;
			nc = (u >= 0);
		end else begin
			u = x + y + extra;
			s = sx + sy + extra;
			nc = (u >= (1 << W));
		end
		nv = (s > (1 << (W - 1)) - 1) || (s < -(1 << (W - 1)));
		q = u[W-1:0];
		if (!arith) begin
			nc = sh[W];
			case (cin.ctrl.op)
				ALU_AND, ALU_TST: q = a & b;
				ALU_EOR, ALU_TEQ: q = a ^ b;
				ALU_ORR:          q = a | b;
				ALU_BIC:          q = a & ~b;
				ALU_MOV:          q = b;
				default:          q = ~b;
			endcase
		end
		cmp_op = cin.ctrl.op inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN};
		r.tag = cin.tag;
		r.has_rd = !cmp_op;
		r.q = q;
		r.flags = f;
		if (cmp_op || cin.set_flags) begin
			r.flags.n = q[W-1];
			r.flags.z = (q == '0);
			r.flags.c = nc;
			if (arith)
				r.flags.v = nv;
		end
		return r;
	endfunction

	// shift amounts lean toward 0, W and beyond W.
	function automatic alu_cmd rand_cmd();
		alu_cmd c;
		c.ctrl.op = alu_op'($urandom_range(0, 15));
		c.ctrl.shop = shift_op'($urandom_range(0, 3));
		case ($urandom_range(0, 7))
			0, 1:    c.shift = 8'd0;
			2:       c.shift = 8'(W);
			3:       c.shift = 8'($urandom_range(W + 1, 255));
			4:       c.shift = 8'(W * $urandom_range(2, 3));
			default: c.shift = 8'($urandom_range(1, W - 1));
		endcase
		c.a = ($urandom_range(0, 5) == 0) ? 16'h7fff : 16'($urandom);
		c.base = ($urandom_range(0, 5) == 0) ? 16'h8000 : 16'($urandom);
		c.set_flags = 1'($urandom_range(0, 1));
		c.tag = 4'($urandom);
		return c;
	endfunction

	task automatic check_result(input alu_result got, input alu_result exp);
		if (got.tag !== exp.tag) begin
			err_value++;
			$display("mismatch res.tag: got %h expected %h", got.tag, exp.tag);
		end
		if (got.has_rd !== exp.has_rd) begin
			err_value++;
			$display("mismatch res.has_rd: got %h expected %h", got.has_rd, exp.has_rd);
		end
		if (got.q !== exp.q) begin
			err_value++;
			$display("mismatch res.q: got %h expected %h", got.q, exp.q);
		end
	endtask

	task automatic check_flags(input psr_flags got, input psr_flags exp);
		if (got !== exp) begin
			err_value++;
			$display("mismatch res.flags: got %h expected %h", got, exp);
		end
	endtask

	task automatic timeout_error(input string what);
		err_other++;
		timed_out = 1'b1;
		$display("timeout: %s", what);
	endtask

	task automatic take_result();
		alu_result e;
		if (exp_q.size() == 0) begin
			err_other++;
			$display("a result came back with no command outstanding");
			return;
		end
		e = exp_q.pop_front();
		n_checked++;
		check_result(res, e);
		check_flags(res.flags, e.flags);
	endtask

	task automatic start_cmd(input alu_cmd c);
		alu_result e;
		if (timed_out)
			return;
		e = predict(c, model_flags);
		model_flags = e.flags;
		exp_q.push_back(e);
		@(negedge clk);
		cmd = c;
		cmd_req = 1'b1;
	endtask

	task automatic finish_cmd();
		int n;
		if (timed_out)
			return;
		n = 0;
		while (cmd_ack !== 1'b1 && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (cmd_ack !== 1'b1) begin
			timeout_error("cmd_ack did not rise for a pending command");
			return;
		end
		cmd_req = 1'b0;
		n = 0;
		while (cmd_ack !== 1'b0 && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (cmd_ack !== 1'b0)
			timeout_error("cmd_ack stayed high after cmd_req fell");
	endtask

	task automatic send_cmd(input alu_cmd c);
		start_cmd(c);
		finish_cmd();
	endtask

	task automatic drain();
		int n;
		if (timed_out)
			return;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0)
			timeout_error("results are still outstanding after the drain limit");
	endtask

	task automatic finish_run();
		$display("results checked %0d, value mismatches %0d, other errors %0d",
		         n_checked, err_value, err_other);
		if (err_value == 0 && err_other == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	endtask

	// answers the output handshake with a random delay before each ack.
	always @(negedge clk) begin
		if (!arst_n) begin
			res_ack = 1'b0;
			ack_delay = 0;
		end else if (res_ack) begin
			if (!res_req)
				res_ack = 1'b0;
		end else if (res_req && !hold_ack) begin
			if (ack_delay > 0) begin
				ack_delay--;
			end else begin
				take_result();
				res_ack = 1'b1;
				ack_delay = ($urandom_range(0, 7) == 0) ? 10 : $urandom_range(0, 2);
			end
		end
	end

	initial begin
		seed = $urandom(32'h1eae);
		arst_n = 1'b0;
		cmd = '0;
		cmd_req = 1'b0;
		res_ack = 1'b0;
		hold_ack = 1'b0;
		ack_seen = 1'b0;
		timed_out = 1'b0;
		model_flags = '0;
		err_value = 0;
		err_other = 0;
		n_checked = 0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		if (cmd_ack !== 1'b0 || res_req !== 1'b0) begin
			err_other++;
			$display("cmd_ack or res_req is not low after reset");
		end

		// an ADC of zeros that leaves the flags alone returns the reset carry and flags.
		first_cmd = '0;
		first_cmd.ctrl.op = ALU_ADC;
		first_cmd.tag = 4'ha;
		send_cmd(first_cmd);

		for (i = 0; i < N_RANDOM && !timed_out; i++) begin
			send_cmd(rand_cmd());
			repeat ($urandom_range(0, 2)) @(negedge clk);
		end
		drain();

		// with res_ack held off, DEPTH commands fill the FIFO and one sits in exec.
		if (!timed_out) begin
			hold_ack = 1'b1;
			for (i = 0; i < DEPTH + 1 && !timed_out; i++)
				send_cmd(rand_cmd());
			start_cmd(rand_cmd());
			for (i = 0; i < 12; i++) begin
				@(negedge clk);
				if (cmd_ack)
					ack_seen = 1'b1;
			end
			if (ack_seen) begin
				err_other++;
				$display("cmd_ack rose while the FIFO was full and res_ack was held off");
			end
			hold_ack = 1'b0;
			finish_cmd();
			drain();
			// a duplicated command would return one more result in this window.
			repeat (20) @(negedge clk);
		end
		finish_run();
	end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD = 8.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

endmodule

// File: rtl/core_alu_top.sv
`timescale 1ns/1ps

module core_alu_top #(
	parameter int W     = 16,
	parameter int DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  core_link_pkg::alu_cmd    cmd,
	input  logic                     cmd_req,
	output logic                     cmd_ack,
	output core_link_pkg::alu_result res,
	output logic                     res_req,
	input  logic                     res_ack
);

	import core_link_pkg::*;

	alu_cmd push_data;
	alu_cmd head;
	logic   push;
	logic   full;
	logic   pop;
	logic   empty;

	core_alu_issue issue (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd       (cmd),
		.cmd_req   (cmd_req),
		.cmd_ack   (cmd_ack),
		.push      (push),
		.push_data (push_data),
		.full      (full)
	);

	core_alu_fifo #(.DEPTH(DEPTH)) fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (push),
		.push_data (push_data),
		.full      (full),
		.pop       (pop),
		.head      (head),
		.empty     (empty)
	);

	core_alu_exec #(.W(W)) exec (
		.clk     (clk),
		.arst_n  (arst_n),
		.head    (head),
		.empty   (empty),
		.pop     (pop),
		.res     (res),
		.res_req (res_req),
		.res_ack (res_ack)
	);

endmodule

// File: rtl/core_alu_exec.sv
`timescale 1ns/1ps

module core_alu_exec #(
	parameter int W = 16
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  core_link_pkg::alu_cmd    head,
	input  logic                     empty,
	output logic                     pop,
	output core_link_pkg::alu_result res,
	output logic                     res_req,
	input  logic                     res_ack
);

	import core_isa_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		PRESENT,
		RELEASE
	} exec_state;

	exec_state    state;
	exec_state    state_next;
	psr_flags     flags;
	psr_flags     flags_next;
	psr_flags     alu_nzcv;
	logic [W-1:0] alu_q;
	logic         alu_v_valid;
	logic         is_compare;
	logic         update;

	core_alu #(.W(W)) alu (
		.ctrl    (head.ctrl),
		.a       (head.a),
		.base    (head.base),
		.shift   (head.shift),
		.c_in    (flags.c),
		.q       (alu_q),
		.nzcv    (alu_nzcv),
		.v_valid (alu_v_valid)
	);

	assign is_compare = head.ctrl.op inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN};
	assign update     = is_compare || head.set_flags;

	// V is only touched by arithmetic ops.
	always_comb begin
		flags_next = flags;
		if (update) begin
			flags_next.n = alu_nzcv.n;
			flags_next.z = alu_nzcv.z;
			flags_next.c = alu_nzcv.c;
			if (alu_v_valid)
				flags_next.v = alu_nzcv.v;
		end
	end

	always_comb begin
		state_next = state;
		pop        = 1'b0;
		case (state)
			IDLE: begin
				if (!empty) begin
					pop        = 1'b1;
					state_next = PRESENT;
				end
			end
			PRESENT: begin
				if (res_ack)
					state_next = RELEASE;
			end
			RELEASE: begin
				if (!res_ack)
					state_next = IDLE;
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			flags <= '0;
		end else begin
			state <= state_next;
			if (pop)
				flags <= flags_next;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			res.tag    <= head.tag;
			res.has_rd <= !is_compare;
			res.q      <= alu_q;
			res.flags  <= flags_next;
		end
	end

	assign res_req = (state == PRESENT);

endmodule

// File: rtl/core_alu_fifo.sv
`timescale 1ns/1ps

module core_alu_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  push,
	input  core_link_pkg::alu_cmd push_data,
	output logic                  full,
	input  logic                  pop,
	output core_link_pkg::alu_cmd head,
	output logic                  empty
);

	import core_link_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	alu_cmd        mem [DEPTH];
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [CW-1:0] count;
	logic          wr_en;
	logic          rd_en;

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;
	assign full  = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign head  = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

endmodule

// File: rtl/core_alu_issue.sv
`timescale 1ns/1ps

module core_alu_issue (
	input  logic                  clk,
	input  logic                  arst_n,
	input  core_link_pkg::alu_cmd cmd,
	input  logic                  cmd_req,
	output logic                  cmd_ack,
	output logic                  push,
	output core_link_pkg::alu_cmd push_data,
	input  logic                  full
);

	typedef enum logic {
		WAIT_REQ,
		WAIT_DROP
	} issue_state;

	issue_state state;
	issue_state state_next;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= WAIT_REQ;
		else
			state <= state_next;
	end

	// a request waits here while the FIFO is full, and that holds off the ack.
	always_comb begin
		state_next = state;
		push       = 1'b0;
		unique case (state)
			WAIT_REQ: begin
				if (cmd_req && !full) begin
					push       = 1'b1;
					state_next = WAIT_DROP;
				end
			end
			WAIT_DROP: begin
				if (!cmd_req)
					state_next = WAIT_REQ;
			end
		endcase
	end

	// cmd is held stable by the sender while cmd_req is high.
	assign push_data = cmd;
	assign cmd_ack   = (state == WAIT_DROP);

endmodule

// File: rtl/core_alu.sv
`timescale 1ns/1ps

module core_alu #(
	parameter int W = 16
) (
	input  core_isa_pkg::alu_control ctrl,
	input  logic [W-1:0]             a,
	input  logic [W-1:0]             base,
	input  logic [7:0]               shift,
	input  logic                     c_in,
	output logic [W-1:0]             q,
	output core_isa_pkg::psr_flags   nzcv,
	output logic                     v_valid
);

	import core_isa_pkg::*;

	logic [W-1:0] b;
	logic         c_shifter;
	logic         swap;
	logic         sub;
	logic         c_in_add;
	logic [W-1:0] add_a;
	logic [W-1:0] add_src;
	logic [W-1:0] add_b;
	logic [W-1:0] q_add;
	logic         c_add;
	logic         v_add;
	logic         c;
	logic         v;

	core_alu_shifter #(.W(W)) shifter (
		.ctrl  (ctrl),
		.base  (base),
		.shift (shift),
		.c_in  (c_in),
		.b     (b),
		.c     (c_shifter)
	);

	// subtraction is a + ~b + 1, so C set means no borrow.
	always_comb begin
		swap     = 1'b0;
		sub      = 1'b0;
		c_in_add = 1'b0;
		case (ctrl.op)
			ALU_SUB, ALU_CMP: begin
				sub      = 1'b1;
				c_in_add = 1'b1;
			end
			ALU_RSB: begin
				swap     = 1'b1;
				sub      = 1'b1;
				c_in_add = 1'b1;
			end
			ALU_ADC: begin
				c_in_add = c_in;
			end
			ALU_SBC: begin
				sub      = 1'b1;
				c_in_add = c_in;
			end
			ALU_RSC: begin
				swap     = 1'b1;
				sub      = 1'b1;
				c_in_add = c_in;
			end
			default: begin
			end
		endcase
	end

	assign add_a   = swap ? b : a;
	assign add_src = swap ? a : b;
	assign add_b   = sub ? ~add_src : add_src;

	assign {c_add, q_add} = {1'b0, add_a} + {1'b0, add_b} + {{W{1'b0}}, c_in_add};
	assign v_add = (add_a[W-1] == add_b[W-1]) && (q_add[W-1] != add_a[W-1]);

	assign v_valid = ctrl.op inside {ALU_SUB, ALU_RSB, ALU_ADD, ALU_ADC,
	                                 ALU_SBC, ALU_RSC, ALU_CMP, ALU_CMN};

	always_comb begin
		unique case (ctrl.op)
			ALU_AND, ALU_TST: q = a & b;
			ALU_BIC:          q = a & ~b;
			ALU_EOR, ALU_TEQ: q = a ^ b;
			ALU_ORR:          q = a | b;
			ALU_MOV:          q = b;
			ALU_MVN:          q = ~b;
			default:          q = q_add;
		endcase
	end

	// logical ops take their carry from the shifter and have no overflow.
	assign c = v_valid ? c_add : c_shifter;
	assign v = v_valid & v_add;

	assign nzcv = {q[W-1], ~|q, c, v};

endmodule

// File: rtl/core_alu_shifter.sv
`timescale 1ns/1ps

module core_alu_shifter #(
	parameter int W = 16
) (
	input  core_isa_pkg::alu_control ctrl,
	input  logic [W-1:0]             base,
	input  logic [7:0]               shift,
	input  logic                     c_in,
	output logic [W-1:0]             b,
	output logic                     c
);

	import core_isa_pkg::*;

	logic [W:0]     lsl_ext;
	logic [W:0]     lsr_ext;
	logic [W:0]     asr_ext;
	logic [7:0]     rot;
	logic [2*W-1:0] ror_ext;

	// the extra bit next to the data catches the last bit shifted out.
	assign lsl_ext = {1'b0, base} << shift;
	assign lsr_ext = {base, 1'b0} >> shift;
	assign asr_ext = $signed({base, 1'b0}) >>> shift;

	assign rot     = 8'(shift % W);
	assign ror_ext = {base, base} >> rot;

	always_comb begin
		b = base;
		c = c_in;
		if (shift != 8'd0) begin
			unique case (ctrl.shop)
				SHIFT_LSL: begin
					b = lsl_ext[W-1:0];
					c = lsl_ext[W];
				end
				SHIFT_LSR: begin
					b = lsr_ext[W:1];
					c = lsr_ext[0];
				end
				SHIFT_ASR: begin
					b = asr_ext[W:1];
					c = asr_ext[0];
				end
				SHIFT_ROR: begin
					// a full turn leaves the value as is but still sets the carry.
					b = ror_ext[W-1:0];
					c = ror_ext[W-1];
				end
			endcase
		end
	end

endmodule

// File: rtl/core_link_pkg.sv
package core_link_pkg;

	import core_isa_pkg::*;

	// one queued data-processing command.
	typedef struct packed {
		alu_control  ctrl;
		logic        set_flags;
		logic [3:0]  tag;
		logic [7:0]  shift;
		logic [15:0] a;
		logic [15:0] base;
	} alu_cmd;

	// flags holds the flag register as it stands after the command.
	typedef struct packed {
		logic [3:0]  tag;
		logic        has_rd;
		logic [15:0] q;
		psr_flags    flags;
	} alu_result;

endpackage

// File: rtl/core_isa_pkg.sv
package core_isa_pkg;

	// data-processing opcodes, in the order of their instruction encoding.
	typedef enum logic [3:0] {
		ALU_AND = 4'h0,
		ALU_EOR = 4'h1,
		ALU_SUB = 4'h2,
		ALU_RSB = 4'h3,
		ALU_ADD = 4'h4,
		ALU_ADC = 4'h5,
		ALU_SBC = 4'h6,
		ALU_RSC = 4'h7,
		ALU_TST = 4'h8,
		ALU_TEQ = 4'h9,
		ALU_CMP = 4'ha,
		ALU_CMN = 4'hb,
		ALU_ORR = 4'hc,
		ALU_MOV = 4'hd,
		ALU_BIC = 4'he,
		ALU_MVN = 4'hf
	} alu_op;

	typedef enum logic [1:0] {
		SHIFT_LSL = 2'b00,
		SHIFT_LSR = 2'b01,
		SHIFT_ASR = 2'b10,
		SHIFT_ROR = 2'b11
	} shift_op;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef struct packed {
		alu_op   op;
		shift_op shop;
	} alu_control;

endpackage
